// ==== design/fu_pkg.sv ====
package fu_pkg;

	localparam int PRF_IDX_W = 6;
	localparam int ROB_IDX_W = 5;
	localparam int BR_MASK_W = 4;

	// physical tag of the hardwired zero register
	localparam logic [PRF_IDX_W-1:0] ZERO_TAG = '0;

	typedef enum logic [2:0] {
		SEL_NONE      = 3'd0,
		SEL_ALU       = 3'd1,
		SEL_UNCOND_BR = 3'd2,
		SEL_COND_BR   = 3'd3,
		SEL_MULT      = 3'd4
	} fu_sel_e;

	// operate format, rb is the upper five bits of literal
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [7:0] literal;
		logic       lit_flag;
		logic [6:0] func;
		logic [4:0] rc;
	} op_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [20:0] disp;
	} br_fmt_t;

	typedef union packed {
		op_fmt_t op;
		br_fmt_t br;
	} inst_u;

	typedef struct packed {
		logic [63:0]          npc;
		logic [63:0]          opa;
		logic [63:0]          opb;
		inst_u                inst;
		logic [PRF_IDX_W-1:0] dest_tag;
		logic [ROB_IDX_W:0]   rob_idx;
		logic [BR_MASK_W-1:0] br_mask;
		logic                 pred_taken;
	} issue_pkt_t;

	typedef struct packed {
		logic                 recovery;
		logic                 pred_correct;
		logic [BR_MASK_W-1:0] tag_fix;
	} br_fix_t;

	typedef struct packed {
		logic                 vld;
		logic [PRF_IDX_W-1:0] tag;
		logic [63:0]          value;
		logic [ROB_IDX_W:0]   rob_idx;
	} wb_t;

	typedef struct packed {
		logic               done;
		logic               taken;
		logic               cond;
		logic               mispredict;
		logic [63:0]        redirect;
		logic [63:0]        pc;
		logic [ROB_IDX_W:0] rob_idx;
	} br_res_t;

	// integer opcodes and function codes
	localparam logic [5:0] OP_INTA = 6'h10;
	localparam logic [5:0] OP_INTL = 6'h11;
	localparam logic [5:0] OP_INTS = 6'h12;
	localparam logic [5:0] OP_INTM = 6'h13;

	localparam logic [6:0] FN_ADDQ   = 7'h20;
	localparam logic [6:0] FN_SUBQ   = 7'h29;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_AND    = 7'h00;
	localparam logic [6:0] FN_BIS    = 7'h20;
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRL    = 7'h34;
	localparam logic [6:0] FN_MULQ   = 7'h20;

	localparam logic [5:0] OP_BR   = 6'h30;
	localparam logic [5:0] OP_BLBC = 6'h38;
	localparam logic [5:0] OP_BEQ  = 6'h39;
	localparam logic [5:0] OP_BLT  = 6'h3a;
	localparam logic [5:0] OP_BLE  = 6'h3b;
	localparam logic [5:0] OP_BLBS = 6'h3c;
	localparam logic [5:0] OP_BNE  = 6'h3d;
	localparam logic [5:0] OP_BGE  = 6'h3e;
	localparam logic [5:0] OP_BGT  = 6'h3f;

	// entry depends on the branch being recovered
	function automatic logic br_squash(input logic [BR_MASK_W-1:0] mask, input br_fix_t fix);
		return fix.recovery && ((mask & fix.tag_fix) != '0);
	endfunction

	function automatic logic [BR_MASK_W-1:0] br_clear(input logic [BR_MASK_W-1:0] mask,
			input br_fix_t fix);
		return fix.pred_correct ? (mask & ~fix.tag_fix) : mask;
	endfunction

endpackage

// ==== design/fu_alu.sv ====
`timescale 1ns/1ps

module fu_alu import fu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  issue_pkt_t           pkt_i,
	input  br_fix_t              fix_i,
	output wb_t                  result_o,
	output logic [BR_MASK_W-1:0] mask_o
);

	op_fmt_t              op;
	logic [63:0]          opa;
	logic [63:0]          opb;
	logic [63:0]          alu_res;
	logic                 vld_q;
	logic [PRF_IDX_W-1:0] tag_q;
	logic [63:0]          value_q;
	logic [ROB_IDX_W:0]   rob_q;
	logic [BR_MASK_W-1:0] mask_q;

	assign op  = pkt_i.inst.op;
	assign opa = pkt_i.opa;
	// literal is zero extended
	assign opb = op.lit_flag ? {56'b0, op.literal} : pkt_i.opb;

	always_comb begin
		alu_res = '0;
		case (op.opcode)
			OP_INTA: begin
				case (op.func)
					FN_ADDQ:   alu_res = opa + opb;
					FN_SUBQ:   alu_res = opa - opb;
					FN_CMPEQ:  alu_res = {63'b0, opa == opb};
					FN_CMPULT: alu_res = {63'b0, opa < opb};
					default:   alu_res = '0;
				endcase
			end
			OP_INTL: begin
				case (op.func)
					FN_AND:  alu_res = opa & opb;
					FN_BIS:  alu_res = opa | opb;
					FN_XOR:  alu_res = opa ^ opb;
					default: alu_res = '0;
				endcase
			end
			OP_INTS: begin
				case (op.func)
					FN_SLL:  alu_res = opa << opb[5:0];
					FN_SRL:  alu_res = opa >> opb[5:0];
					default: alu_res = '0;
				endcase
			end
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= start_i & ~br_squash(pkt_i.br_mask, fix_i);
		end
	end

	always_ff @(posedge clk) begin
		tag_q   <= pkt_i.dest_tag;
		value_q <= alu_res;
		rob_q   <= pkt_i.rob_idx;
		mask_q  <= br_clear(pkt_i.br_mask, fix_i);
	end

	assign result_o = '{vld: vld_q, tag: tag_q, value: value_q, rob_idx: rob_q};
	assign mask_o   = mask_q;

endmodule

// ==== design/fu_mult.sv ====
`timescale 1ns/1ps

module fu_mult import fu_pkg::*; #(
	parameter int MULT_STAGES = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       start_i,
	input  issue_pkt_t pkt_i,
	input  br_fix_t    fix_i,
	output wb_t        result_o,
	output logic       done_pre_o
);

	// multiplier bits consumed per stage
	localparam int CHUNK = 64 / MULT_STAGES;

	typedef struct packed {
		logic [PRF_IDX_W-1:0] tag;
		logic [ROB_IDX_W:0]   rob_idx;
		logic [BR_MASK_W-1:0] mask;
		logic [63:0]          mcand;
		logic [63:0]          mplier;
		logic [63:0]          prod;
	} stage_t;

	logic [MULT_STAGES-1:0] vld_q;
	logic [MULT_STAGES-1:0] vld_nxt;
	stage_t                 data_q  [MULT_STAGES];
	stage_t                 data_nxt[MULT_STAGES];

	for (genvar k = 0; k < MULT_STAGES; k++) begin : g_stage
		stage_t      in_s;
		logic        in_vld;
		logic [63:0] pp;

		if (k == 0) begin : g_first
			assign in_vld = start_i;
			assign in_s   = '{tag: pkt_i.dest_tag, rob_idx: pkt_i.rob_idx,
				mask: pkt_i.br_mask, mcand: pkt_i.opa, mplier: pkt_i.opb, prod: '0};
		end else begin : g_next
			assign in_vld = vld_q[k-1];
			assign in_s   = data_q[k-1];
		end

		// low bits of mcand times this chunk of the multiplier
		assign pp = in_s.mcand * {{(64-CHUNK){1'b0}}, in_s.mplier[CHUNK-1:0]};

		assign vld_nxt[k] = in_vld & ~br_squash(in_s.mask, fix_i);
		assign data_nxt[k] = '{
			tag:     in_s.tag,
			rob_idx: in_s.rob_idx,
			mask:    br_clear(in_s.mask, fix_i),
			mcand:   in_s.mcand << CHUNK,
			mplier:  in_s.mplier >> CHUNK,
			prod:    in_s.prod + pp
		};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= '0;
		end else begin
			vld_q <= vld_nxt;
		end
	end

	always_ff @(posedge clk) begin
		data_q <= data_nxt;
	end

	assign result_o = '{
		vld:     vld_q[MULT_STAGES-1],
		tag:     data_q[MULT_STAGES-1].tag,
		value:   data_q[MULT_STAGES-1].prod,
		rob_idx: data_q[MULT_STAGES-1].rob_idx
	};

	// finishes at the next edge
	assign done_pre_o = vld_q[MULT_STAGES-2];

endmodule

// ==== design/fu_br.sv ====
`timescale 1ns/1ps

module fu_br import fu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start_i,
	input  logic       cond_i,
	input  issue_pkt_t pkt_i,
	output br_res_t    br_o
);

	br_fmt_t     bf;
	logic [63:0] opa;
	logic        opa_zero;
	logic        cond_true;
	logic        taken;
	logic [63:0] target;
	br_res_t     res_q;

	assign bf       = pkt_i.inst.br;
	assign opa      = pkt_i.opa;
	assign opa_zero = (opa == 64'b0);

	always_comb begin
		case (bf.opcode)
			OP_BEQ:  cond_true = opa_zero;
			OP_BNE:  cond_true = ~opa_zero;
			OP_BLT:  cond_true = opa[63];
			OP_BGE:  cond_true = ~opa[63];
			OP_BLE:  cond_true = opa[63] | opa_zero;
			OP_BGT:  cond_true = ~opa[63] & ~opa_zero;
			OP_BLBC: cond_true = ~opa[0];
			OP_BLBS: cond_true = opa[0];
			default: cond_true = 1'b0;
		endcase
	end

	// unconditional always taken
	assign taken  = cond_i ? cond_true : 1'b1;
	assign target = pkt_i.npc + {{41{bf.disp[20]}}, bf.disp, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			res_q.done <= 1'b0;
		end else begin
			res_q.done <= start_i;
		end
		res_q.taken      <= taken;
		res_q.cond       <= cond_i;
		res_q.mispredict <= taken ^ pkt_i.pred_taken;
		res_q.redirect   <= taken ? target : pkt_i.npc;
		res_q.pc         <= pkt_i.npc - 64'd4;
		res_q.rob_idx    <= pkt_i.rob_idx;
	end

	assign br_o = res_q;

endmodule

// ==== design/fu_main.sv ====
`timescale 1ns/1ps

module fu_main import fu_pkg::*; #(
	parameter int MULT_STAGES = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       iss_vld_i,
	input  fu_sel_e    sel_i,
	input  issue_pkt_t iss_i,
	input  br_fix_t    fix_i,
	output wb_t        wb_o,
	output logic       wb_stall_o,
	output br_res_t    br_o
);

	logic                 alu_start;
	logic                 mult_start;
	logic                 br_start;
	logic                 br_cond;
	wb_t                  alu_res;
	logic [BR_MASK_W-1:0] alu_mask;
	logic                 alu_live;
	wb_t                  mult_res;
	logic                 mult_done_pre;
	wb_t                  wb;

	// one start strobe per valid issue
	always_comb begin
		alu_start  = 1'b0;
		mult_start = 1'b0;
		br_start   = 1'b0;
		br_cond    = 1'b0;
		if (iss_vld_i) begin
			case (sel_i)
				SEL_ALU:       alu_start = 1'b1;
				SEL_MULT:      mult_start = 1'b1;
				SEL_UNCOND_BR: br_start = 1'b1;
				SEL_COND_BR: begin
					br_start = 1'b1;
					br_cond  = 1'b1;
				end
				default: ;
			endcase
		end
	end

	fu_alu u_alu (
		.clk      (clk),
		.rst      (rst),
		.start_i  (alu_start),
		.pkt_i    (iss_i),
		.fix_i    (fix_i),
		.result_o (alu_res),
		.mask_o   (alu_mask)
	);

	fu_mult #(
		.MULT_STAGES (MULT_STAGES)
	) u_mult (
		.clk        (clk),
		.rst        (rst),
		.start_i    (mult_start),
		.pkt_i      (iss_i),
		.fix_i      (fix_i),
		.result_o   (mult_res),
		.done_pre_o (mult_done_pre)
	);

	fu_br u_br (
		.clk     (clk),
		.rst     (rst),
		.start_i (br_start),
		.cond_i  (br_cond),
		.pkt_i   (iss_i),
		.br_o    (br_o)
	);

	// an ALU result being squashed yields the bus
	assign alu_live = alu_res.vld & ~br_squash(alu_mask, fix_i);

	always_comb begin
		if (alu_live) begin
			wb = alu_res;
		end else if (mult_res.vld) begin
			wb = mult_res;
		end else begin
			wb = '{vld: 1'b0, tag: ZERO_TAG, value: '0, rob_idx: '0};
		end
	end

	// nothing is written back during recovery
	always_comb begin
		wb_o     = wb;
		wb_o.vld = wb.vld & ~fix_i.recovery;
	end

	assign wb_stall_o = mult_done_pre;

endmodule

// ==== tests/fu_main_tb.sv ====
`timescale 1ns/1ps

module tb_fu_main import fu_pkg::*; ();

	localparam int MULT_STAGES = 4;
	localparam logic [63:0] SEED = 64'd72;
	localparam int N_RAND = 2000;
	// random phase plus directed and drain cycles stay far below this
	localparam int MAX_CYCLES = 2 * N_RAND;

	localparam logic [5:0] ALU_OPC[9] = '{OP_INTA, OP_INTA, OP_INTA, OP_INTA,
		OP_INTL, OP_INTL, OP_INTL, OP_INTS, OP_INTS};
	localparam logic [6:0] ALU_FN[9] = '{FN_ADDQ, FN_SUBQ, FN_CMPEQ, FN_CMPULT,
		FN_AND, FN_BIS, FN_XOR, FN_SLL, FN_SRL};
	localparam logic [5:0] COND_OPC[8] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
		OP_BLE, OP_BGT, OP_BLBC, OP_BLBS};

	typedef struct {
		int                   due;
		logic                 is_mult;
		logic [BR_MASK_W-1:0] mask;
		wb_t                  wb;
	} pend_t;

	typedef struct {
		int      due;
		br_res_t res;
	} br_exp_t;

	logic       clk = 1'b0;
	logic       rst;
	logic       iss_vld_i;
	fu_sel_e    sel_i;
	issue_pkt_t iss_i;
	br_fix_t    fix_i;
	wb_t        wb_o;
	logic       wb_stall_o;
	br_res_t    br_o;

	logic [63:0] lcg_state = SEED;
	int cyc = 0;
	int tmo_cnt = 0;
	int n_checks = 0;
	int n_errors = 0;
	int n_alu = 0;
	int n_mult = 0;
	int n_br = 0;
	int n_squash = 0;
	// expected results keyed by the edge where they are sampled
	pend_t   wb_q[$];
	br_exp_t br_q[$];

	fu_main #(
		.MULT_STAGES (MULT_STAGES)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.iss_vld_i  (iss_vld_i),
		.sel_i      (sel_i),
		.iss_i      (iss_i),
		.fix_i      (fix_i),
		.wb_o       (wb_o),
		.wb_stall_o (wb_stall_o),
		.br_o       (br_o)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state[63:32];
	endfunction

	function automatic logic [63:0] alu_model(input logic [5:0] opc, input logic [6:0] fn,
			input logic [63:0] a, input logic [63:0] b);
		logic [63:0] r;
		r = 64'd0;
		if (opc == OP_INTA) begin
			if (fn == FN_ADDQ) r = a + b;
			else if (fn == FN_SUBQ) r = a - b;
			else if (fn == FN_CMPEQ) r = 64'(a == b);
			else if (fn == FN_CMPULT) r = 64'(a < b);
		end else if (opc == OP_INTL) begin
			if (fn == FN_AND) r = a & b;
			else if (fn == FN_BIS) r = a | b;
			else if (fn == FN_XOR) r = a ^ b;
		end else if (opc == OP_INTS) begin
			if (fn == FN_SLL) r = a << b[5:0];
			else if (fn == FN_SRL) r = a >> b[5:0];
		end
		return r;
	endfunction

	function automatic br_res_t br_model(input issue_pkt_t p, input logic cond);
		br_res_t            r;
		logic               t;
		logic signed [63:0] a;
		logic [63:0]        offset;
		a = signed'(p.opa);
		offset = 64'(signed'(p.inst.br.disp)) * 64'd4;
		t = 1'b1;
		if (cond) begin
			case (p.inst.br.opcode)
				OP_BEQ:  t = (a == 64'sd0);
				OP_BNE:  t = (a != 64'sd0);
				OP_BLT:  t = (a < 64'sd0);
				OP_BGE:  t = (a >= 64'sd0);
				OP_BLE:  t = (a <= 64'sd0);
				OP_BGT:  t = (a > 64'sd0);
				OP_BLBC: t = ~p.opa[0];
				OP_BLBS: t = p.opa[0];
				default: t = 1'b0;
			endcase
		end
		r.done       = 1'b1;
		r.taken      = t;
		r.cond       = cond;
		r.mispredict = (t != p.pred_taken);
		r.redirect   = t ? p.npc + offset : p.npc;
		r.pc         = p.npc - 64'd4;
		r.rob_idx    = p.rob_idx;
		return r;
	endfunction

	function automatic issue_pkt_t random_pkt(input fu_sel_e sel);
		issue_pkt_t  p;
		logic [31:0] r;
		int          k;
		p.npc[63:32] = lcg_next();
		p.npc[31:0]  = lcg_next() & ~32'h3;
		p.opa[63:32] = lcg_next();
		p.opa[31:0]  = lcg_next();
		p.opb[63:32] = lcg_next();
		p.opb[31:0]  = lcg_next();
		r = lcg_next();
		// corner operands for compares and zero tests
		if (r[1:0] == 2'd0) p.opb = p.opa;
		if (r[3:2] == 2'd0) p.opa = 64'd0;
		p.dest_tag   = 6'(r[21:16]);
		p.rob_idx    = 6'(r[27:22]);
		p.pred_taken = r[28];
		p.br_mask    = '0;
		if (sel == SEL_ALU) begin
			k = int'(lcg_next() % 32'd9);
			p.inst.op = '{opcode: ALU_OPC[k], ra: 5'(r[8:4]), literal: 8'(lcg_next()),
				lit_flag: r[30], func: ALU_FN[k], rc: 5'(r[13:9])};
		end else if (sel == SEL_MULT) begin
			p.inst.op = '{opcode: OP_INTM, ra: 5'(r[8:4]), literal: 8'd0,
				lit_flag: 1'b0, func: FN_MULQ, rc: 5'(r[13:9])};
		end else if (sel == SEL_COND_BR) begin
			k = int'(lcg_next() % 32'd8);
			p.inst.br = '{opcode: COND_OPC[k], ra: 5'(r[8:4]), disp: 21'(lcg_next())};
		end else begin
			p.inst.br = '{opcode: OP_BR, ra: 5'(r[8:4]), disp: 21'(lcg_next())};
		end
		return p;
	endfunction

	function automatic br_fix_t make_fix(input logic rec, input logic ok,
			input logic [BR_MASK_W-1:0] tag);
		return '{recovery: rec, pred_correct: ok, tag_fix: tag};
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		n_checks++;
		assert (act == exp) else begin
			n_errors++;
			$display("Error %s: expected %h, actual %h (cycle %0d)", name, exp, act, cyc);
		end
	endtask

	// one issue cycle, driven on the falling edge and recorded in the model
	task automatic step(input logic vld, input fu_sel_e sel,
			input logic [BR_MASK_W-1:0] mask, input br_fix_t fix);
		issue_pkt_t  pkt;
		pend_t       e;
		br_exp_t     b;
		logic        go;
		logic [63:0] opb_eff;
		@(negedge clk);
		pkt = random_pkt(sel);
		pkt.br_mask = mask;
		go = vld && !(sel == SEL_ALU && wb_stall_o);
		iss_vld_i = go;
		sel_i     = sel;
		iss_i     = pkt;
		fix_i     = fix;
		opb_eff = pkt.inst.op.lit_flag ? {56'd0, pkt.inst.op.literal} : pkt.opb;
		if (go && (sel == SEL_ALU || sel == SEL_MULT)) begin
			e.due     = cyc + 1 + ((sel == SEL_MULT) ? MULT_STAGES : 1);
			e.is_mult = (sel == SEL_MULT);
			e.mask    = mask;
			e.wb.vld  = 1'b1;
			e.wb.tag  = pkt.dest_tag;
			e.wb.value = e.is_mult ? pkt.opa * pkt.opb :
				alu_model(pkt.inst.op.opcode, pkt.inst.op.func, pkt.opa, opb_eff);
			e.wb.rob_idx = pkt.rob_idx;
			wb_q.push_back(e);
		end else if (go && (sel == SEL_UNCOND_BR || sel == SEL_COND_BR)) begin
			b.due = cyc + 2;
			b.res = br_model(pkt, sel == SEL_COND_BR);
			br_q.push_back(b);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) step(1'b0, SEL_NONE, '0, '0);
	endtask

	task automatic check_wb();
		int    idx;
		logic  stall_exp;
		string name;
		idx = -1;
		stall_exp = 1'b0;
		foreach (wb_q[i]) begin
			if (wb_q[i].due == cyc) idx = i;
			if (wb_q[i].due == cyc + 1 && wb_q[i].is_mult) stall_exp = 1'b1;
		end
		compare("stall hint", 64'(stall_exp), 64'(wb_stall_o));
		if (idx < 0) begin
			compare("idle bus valid", 64'd0, 64'(wb_o.vld));
			compare("idle bus tag", 64'(ZERO_TAG), 64'(wb_o.tag));
			compare("idle bus value", 64'd0, wb_o.value);
		end else if (fix_i.recovery) begin
			compare("valid in recovery cycle", 64'd0, 64'(wb_o.vld));
		end else begin
			name = wb_q[idx].is_mult ? "multiplier write-back" : "ALU write-back";
			compare({name, " valid"}, 64'd1, 64'(wb_o.vld));
			compare({name, " tag"}, 64'(wb_q[idx].wb.tag), 64'(wb_o.tag));
			compare({name, " value"}, wb_q[idx].wb.value, wb_o.value);
			compare({name, " rob index"}, 64'(wb_q[idx].wb.rob_idx), 64'(wb_o.rob_idx));
			if (wb_q[idx].is_mult) n_mult++;
			else n_alu++;
		end
	endtask

	task automatic check_br();
		int idx;
		idx = -1;
		foreach (br_q[i]) begin
			if (br_q[i].due == cyc) idx = i;
		end
		if (idx < 0) begin
			compare("branch done when idle", 64'd0, 64'(br_o.done));
		end else begin
			compare("branch done", 64'd1, 64'(br_o.done));
			compare("branch taken", 64'(br_q[idx].res.taken), 64'(br_o.taken));
			compare("branch cond", 64'(br_q[idx].res.cond), 64'(br_o.cond));
			compare("branch mispredict", 64'(br_q[idx].res.mispredict), 64'(br_o.mispredict));
			compare("branch redirect", br_q[idx].res.redirect, br_o.redirect);
			compare("branch pc", br_q[idx].res.pc, br_o.pc);
			compare("branch rob index", 64'(br_q[idx].res.rob_idx), 64'(br_o.rob_idx));
			n_br++;
		end
	endtask

	// retire checked entries, then apply this edge's branch fix
	task automatic advance_model();
		pend_t   keep[$];
		br_exp_t bkeep[$];
		pend_t   e;
		foreach (wb_q[i]) begin
			e = wb_q[i];
			if (e.due > cyc) begin
				if (fix_i.recovery && (e.mask & fix_i.tag_fix) != '0) begin
					n_squash++;
				end else begin
					if (fix_i.pred_correct) e.mask = e.mask & ~fix_i.tag_fix;
					keep.push_back(e);
				end
			end
		end
		wb_q = keep;
		foreach (br_q[i]) begin
			if (br_q[i].due > cyc) bkeep.push_back(br_q[i]);
		end
		br_q = bkeep;
	endtask

	always @(posedge clk) begin
		cyc++;
		if (!rst) begin
			check_wb();
			check_br();
		end
		advance_model();
	end

	always @(posedge clk) begin
		tmo_cnt <= tmo_cnt + 1;
		if (tmo_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		fu_sel_e     sel;
		br_fix_t     fix;
		rst       = 1'b1;
		iss_vld_i = 1'b0;
		sel_i     = SEL_NONE;
		iss_i     = '0;
		fix_i     = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle(4);

		repeat (N_RAND) begin
			r = lcg_next();
			fix = make_fix(r[7:4] == 4'd0, r[7:4] == 4'd1, 4'(4'b0001 << r[9:8]));
			if (r[3:0] < 4'd5) sel = SEL_ALU;
			else if (r[3:0] < 4'd9) sel = SEL_MULT;
			else if (r[3:0] < 4'd11) sel = SEL_UNCOND_BR;
			else if (r[3:0] < 4'd14) sel = SEL_COND_BR;
			else if (r[3:0] == 4'd14) sel = SEL_NONE;
			else if (r[17:16] == 2'd0) sel = fu_sel_e'(3'd6);
			else sel = fu_sel_e'({1'b1, r[17:16]});
			step(r[31:29] != 3'd0, sel, 4'(r[13:10]), fix);
		end
		idle(MULT_STAGES + 3);

		// matching recovery squashes a multiply
		step(1'b1, SEL_MULT, 4'b0010, '0);
		step(1'b0, SEL_NONE, '0, make_fix(1'b1, 1'b0, 4'b0010));
		idle(6);
		// recovery on another branch leaves it alone
		step(1'b1, SEL_MULT, 4'b0010, '0);
		step(1'b0, SEL_NONE, '0, make_fix(1'b1, 1'b0, 4'b0100));
		idle(6);
		// confirmed branch, later recovery on the same bit
		step(1'b1, SEL_MULT, 4'b0001, '0);
		step(1'b0, SEL_NONE, '0, make_fix(1'b0, 1'b1, 4'b0001));
		step(1'b0, SEL_NONE, '0, make_fix(1'b1, 1'b0, 4'b0001));
		idle(6);
		// ALU squashed at issue, then in its write-back cycle
		step(1'b1, SEL_ALU, 4'b1000, make_fix(1'b1, 1'b0, 4'b1000));
		idle(2);
		step(1'b1, SEL_ALU, 4'b0100, '0);
		step(1'b0, SEL_NONE, '0, make_fix(1'b1, 1'b0, 4'b0100));
		idle(MULT_STAGES + 3);

		if (wb_q.size() != 0 || br_q.size() != 0) begin
			n_errors++;
			$display("some expected results were never seen on the outputs");
		end
		$display("checks %0d, errors %0d, alu %0d, mult %0d, branch %0d, squashed %0d",
			n_checks, n_errors, n_alu, n_mult, n_br, n_squash);
		if (n_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
design/fu_pkg.sv
design/fu_alu.sv
design/fu_mult.sv
design/fu_br.sv
design/fu_main.sv
tests/fu_main_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log for a failure
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_fu_main \
	-f project.f -o tb_fu_main > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_fu_main > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
